// File: bru_unit.f
source/bru_pkg.sv
source/bru_decoder.sv
source/bru_regfile.sv
source/bru_pipe.sv
source/bru_unit.sv
sim/bru_unit_checker.sv
sim/bru_unit_tb.sv

// File: sim/bru_unit_tb.sv
// branch unit random testbench
`timescale 1ns/10ps

module bru_unit_tb;

  import bru_pkg::*;

  localparam logic [31:0] SEED       = 32'h196e_67eb;
  localparam int          NUM_CYCLES = 3000;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt;
    vaddr_t  pc;
    logic    taken;
    vaddr_t  target;
    logic    mis;
    logic    wr;
    rnid_t   rd;
  } item_t;

  logic     i_clk;
  logic     i_reset_n;
  logic     i_issue_valid;
  inst_t    i_issue_inst;
  vaddr_t   i_issue_pc;
  cmt_id_t  i_issue_cmt_id;
  rnid_t    i_issue_rs1;
  rnid_t    i_issue_rs2;
  rnid_t    i_issue_rd;
  logic     i_issue_pred_taken;
  vaddr_t   i_issue_pred_target;
  logic     i_rf_wr_valid;
  rnid_t    i_rf_wr_rnid;
  xlen_t    i_rf_wr_data;
  logic     o_upd_valid;
  cmt_id_t  o_upd_cmt_id;
  vaddr_t   o_upd_pc;
  logic     o_upd_taken;
  vaddr_t   o_upd_target;
  logic     o_upd_mispredict;
  logic     o_wr_valid;
  rnid_t    o_wr_rnid;
  xlen_t    o_wr_data;

  logic [31:0] rng_state;
  xlen_t       mirror [64];
  item_t       stg [3];  // model of ex0, ex1, ex2
  item_t       pend;     // stimulus waiting for the next edge
  cmt_id_t     next_cmt;
  logic        swap_pair;
  int          cycle;
  int          guard;

  bru_unit #(
    .PHY_REG_NUM (64)
  ) dut_i (.*);

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // age by distance around the commit id ring
  function automatic bit younger_than(input cmt_id_t a, input cmt_id_t b);
    cmt_id_t d;
    d = a - b;
    return (d != 6'd0) && (d < 6'd32);
  endfunction

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s cycle %0d: expected %0h, actual %0h", name, cycle, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cmt_id(input string name, input cmt_id_t exp, input cmt_id_t act);
    if (act !== exp) begin
      $display("FAILED %s cycle %0d: expected %0h, actual %0h", name, cycle, exp, act);
      stop_run();
    end
  endtask

  task automatic check_vaddr(input string name, input vaddr_t exp, input vaddr_t act);
    if (act !== exp) begin
      $display("FAILED %s cycle %0d: expected %h, actual %h", name, cycle, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rnid(input string name, input rnid_t exp, input rnid_t act);
    if (act !== exp) begin
      $display("FAILED %s cycle %0d: expected %0h, actual %0h", name, cycle, exp, act);
      stop_run();
    end
  endtask

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("FAILED %s cycle %0d: expected %h, actual %h", name, cycle, exp, act);
      stop_run();
    end
  endtask

  task automatic drive_idle();
    pend.valid    = 1'b0;
    i_issue_valid = 1'b0;
    i_rf_wr_valid = 1'b0;
  endtask

  // ------------------------------
  // random issue and register write
  // ------------------------------
  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] q;
    logic [31:0] w;
    logic [31:0] imm;
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rdf;
    rnid_t       rs1;
    rnid_t       rs2;
    vaddr_t      pc;
    xlen_t       a;
    xlen_t       b;
    inst_t       inst;
    vaddr_t      tgt;
    logic        res;
    logic        p_taken;
    vaddr_t      p_target;
    r   = next_rand();
    q   = next_rand();
    w   = next_rand();
    imm = next_rand();
    pc  = next_rand();
    pc[1:0] = 2'b00;
    kind = r[2:0];
    f3   = (kind < 3'd2) ? kind : kind + 3'd2;  // 0,1,4,5,6,7
    rdf  = (r[4:3] == 2'b00) ? 5'd0 : r[9:5];
    rs1  = {2'b00, r[13:10]};  // few registers, so equal operands show up
    rs2  = {2'b00, r[17:14]};
    a    = mirror[rs1];
    b    = mirror[rs2];
    case (kind)
      3'd6: begin // jal
        imm  = {{11{imm[20]}}, imm[20:1], 1'b0};
        inst = {imm[20], imm[10:1], imm[11], imm[19:12], rdf, 7'b1101111};
        tgt  = pc + imm;
        res  = 1'b1;
      end
      3'd7: begin // jalr
        imm  = {{20{imm[11]}}, imm[11:0]};
        inst = {imm[11:0], r[31:27], 3'b000, rdf, 7'b1100111};
        tgt  = (a + imm) & ~32'd1;
        res  = 1'b1;
      end
      default: begin
        imm  = {{19{imm[12]}}, imm[12:1], 1'b0};
        inst = {imm[12], imm[10:5], r[31:27], r[31:27], f3, imm[4:1], imm[11], 7'b1100011};
        tgt  = pc + imm;
        case (kind)
          3'd0:    res = (a == b);
          3'd1:    res = (a != b);
          3'd2:    res = ($signed(a) < $signed(b));
          3'd3:    res = !($signed(a) < $signed(b));
          3'd4:    res = (a < b);
          default: res = !(a < b);
        endcase
      end
    endcase
    p_taken  = res;
    p_target = tgt;
    case (q[2:0])
      3'd5: p_target = tgt ^ 32'h0000_0010;  // right direction but wrong target
      3'd6: p_taken  = ~res;
      3'd7: begin
        p_taken  = q[3];
        p_target = {q[31:4], 4'b0000};
      end
      default: ;
    endcase
    // the two ids of a pair may issue in swapped order
    if (!next_cmt[0]) swap_pair = w[8];
    pend.valid  = (r[26:24] != 3'b000);
    pend.cmt    = next_cmt ^ cmt_id_t'(swap_pair);
    pend.pc     = pc;
    pend.taken  = res;
    pend.target = res ? tgt : pc + 32'd4;
    pend.mis    = (res != p_taken) || (res && p_taken && (tgt != p_target));
    pend.wr     = (kind >= 3'd6) && (rdf != 5'd0);
    pend.rd     = r[23:18];
    if (pend.valid) next_cmt = next_cmt + 6'd1;
    i_issue_valid       = pend.valid;
    i_issue_inst        = inst;
    i_issue_pc          = pc;
    i_issue_cmt_id      = pend.cmt;
    i_issue_rs1         = rs1;
    i_issue_rs2         = rs2;
    i_issue_rd          = pend.rd;
    i_issue_pred_taken  = p_taken;
    i_issue_pred_target = p_target;
    // the write lands after the read above on the same edge
    i_rf_wr_valid = w[0];
    i_rf_wr_rnid  = {2'b00, w[4:1]};
    case (w[7:5])
      3'd0:    i_rf_wr_data = 32'h0000_0000;
      3'd1:    i_rf_wr_data = 32'h0000_0001;
      3'd2:    i_rf_wr_data = 32'h7fff_ffff;
      3'd3:    i_rf_wr_data = 32'h8000_0000;
      3'd4:    i_rf_wr_data = 32'hffff_ffff;
      default: i_rf_wr_data = next_rand();
    endcase
    if (w[0]) mirror[i_rf_wr_rnid] = i_rf_wr_data;
  endtask

  // one clock of model, checks, then new stimulus
  task automatic step_cycle(input bit active);
    cmt_id_t kill_cmt;
    logic    flush;
    @(posedge i_clk);
    #1;
    kill_cmt = stg[2].cmt;
    flush    = stg[2].valid & stg[2].mis;
    stg[2]   = stg[1];
    stg[1]   = stg[0];
    stg[0]   = pend;
    if (flush) begin
      if (younger_than(stg[2].cmt, kill_cmt)) stg[2].valid = 1'b0;
      if (younger_than(stg[1].cmt, kill_cmt)) stg[1].valid = 1'b0;
    end
    if (dut_i.checker_i.fail_count != 0) begin
      $display("an output assertion failed at cycle %0d", cycle);
      stop_run();
    end
    check_bit("upd_valid", stg[2].valid, o_upd_valid);
    check_bit("wr_valid", stg[2].valid & stg[2].wr, o_wr_valid);
    if (stg[2].valid) begin
      check_cmt_id("upd_cmt_id", stg[2].cmt, o_upd_cmt_id);
      check_vaddr("upd_pc", stg[2].pc, o_upd_pc);
      check_bit("upd_taken", stg[2].taken, o_upd_taken);
      check_vaddr("upd_target", stg[2].target, o_upd_target);
      check_bit("upd_mispredict", stg[2].mis, o_upd_mispredict);
      if (stg[2].wr) begin
        check_rnid("wr_rnid", stg[2].rd, o_wr_rnid);
        check_xlen("wr_data", stg[2].pc + 32'd4, o_wr_data);
      end
    end
    if (active) drive_random();
    else drive_idle();
  endtask

  initial begin
    i_clk               = 1'b0;
    i_reset_n           = 1'b0;
    i_issue_valid       = 1'b0;
    i_issue_inst        = '0;
    i_issue_pc          = '0;
    i_issue_cmt_id      = '0;
    i_issue_rs1         = '0;
    i_issue_rs2         = '0;
    i_issue_rd          = '0;
    i_issue_pred_taken  = 1'b0;
    i_issue_pred_target = '0;
    i_rf_wr_valid       = 1'b0;
    i_rf_wr_rnid        = '0;
    i_rf_wr_data        = '0;
    rng_state = SEED;
    next_cmt  = '0;
    swap_pair = 1'b0;
    cycle     = 0;
    pend      = '0;
    for (int i = 0; i < 3; i++) stg[i] = '0;
    for (int i = 0; i < 64; i++) mirror[i] = '0;
    for (int i = 0; i < 8; i++) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    check_bit("reset upd_valid", 1'b0, o_upd_valid);
    check_bit("reset wr_valid", 1'b0, o_wr_valid);
    for (cycle = 0; cycle < NUM_CYCLES; cycle++) step_cycle(1'b1);
    // let the last branches report
    guard = 0;
    while (pend.valid || stg[0].valid || stg[1].valid || stg[2].valid) begin
      step_cycle(1'b0);
      cycle++;
      guard++;
      if (guard > 8) begin
        $display("pipeline did not drain within 8 cycles");
        stop_run();
      end
    end
    step_cycle(1'b0);
    if (dut_i.checker_i.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

// File: sim/bru_unit_checker.sv
// branch unit output checks
`timescale 1ns/10ps

module bru_unit_checker (
  input logic             i_clk,
  input logic             i_reset_n,
  input logic             i_upd_valid,
  input bru_pkg::cmt_id_t i_upd_cmt_id,
  input bru_pkg::vaddr_t  i_upd_pc,
  input logic             i_upd_taken,
  input bru_pkg::vaddr_t  i_upd_target,
  input logic             i_upd_mispredict,
  input logic             i_wr_valid,
  input bru_pkg::rnid_t   i_wr_rnid,
  input bru_pkg::xlen_t   i_wr_data
);

  int unsigned fail_count = 0; // polled by the testbench

  // a link write never comes without its update
  a_wr_with_upd: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |-> i_upd_valid)
    else begin
      fail_count++;
      $error("link write without branch update");
    end

  a_target_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_upd_valid |-> !i_upd_target[0])
    else begin
      fail_count++;
      $error("update target has bit 0 set");
    end

  // known values on the strobes and on every field they qualify
  a_no_x: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown({i_upd_valid, i_wr_valid}) &&
    (!i_upd_valid ||
     !$isunknown({i_upd_cmt_id, i_upd_pc, i_upd_taken, i_upd_target, i_upd_mispredict})) &&
    (!i_wr_valid || !$isunknown({i_wr_rnid, i_wr_data})))
    else begin
      fail_count++;
      $error("unknown value on a valid output");
    end

endmodule

bind bru_unit bru_unit_checker checker_i (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_upd_valid      (o_upd_valid),
  .i_upd_cmt_id     (o_upd_cmt_id),
  .i_upd_pc         (o_upd_pc),
  .i_upd_taken      (o_upd_taken),
  .i_upd_target     (o_upd_target),
  .i_upd_mispredict (o_upd_mispredict),
  .i_wr_valid       (o_wr_valid),
  .i_wr_rnid        (o_wr_rnid),
  .i_wr_data        (o_wr_data)
);

// File: source/bru_unit.sv
// branch unit top level
`timescale 1ns/10ps

module bru_unit #(
  parameter int PHY_REG_NUM = 64
) (
  input  logic               i_clk,
  input  logic               i_reset_n,

  // issue
  input  logic               i_issue_valid,
  input  bru_pkg::inst_t     i_issue_inst,
  input  bru_pkg::vaddr_t    i_issue_pc,
  input  bru_pkg::cmt_id_t   i_issue_cmt_id,
  input  bru_pkg::rnid_t     i_issue_rs1,
  input  bru_pkg::rnid_t     i_issue_rs2,
  input  bru_pkg::rnid_t     i_issue_rd,
  input  logic               i_issue_pred_taken,
  input  bru_pkg::vaddr_t    i_issue_pred_target,

  // external write back
  input  logic               i_rf_wr_valid,
  input  bru_pkg::rnid_t     i_rf_wr_rnid,
  input  bru_pkg::xlen_t     i_rf_wr_data,

  output logic               o_upd_valid,
  output bru_pkg::cmt_id_t   o_upd_cmt_id,
  output bru_pkg::vaddr_t    o_upd_pc,
  output logic               o_upd_taken,
  output bru_pkg::vaddr_t    o_upd_target,
  output logic               o_upd_mispredict,

  output logic               o_wr_valid,
  output bru_pkg::rnid_t     o_wr_rnid,
  output bru_pkg::xlen_t     o_wr_data
);

  import bru_pkg::*;

  rnid_t w_rs1_rnid;
  rnid_t w_rs2_rnid;
  xlen_t w_rs1_data;
  xlen_t w_rs2_data;

  bru_regfile #(
    .PHY_REG_NUM (PHY_REG_NUM)
  ) u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr_valid (i_rf_wr_valid),
    .i_wr_rnid  (i_rf_wr_rnid),
    .i_wr_data  (i_rf_wr_data),
    .i_rd0_rnid (w_rs1_rnid),
    .i_rd1_rnid (w_rs2_rnid),
    .o_rd0_data (w_rs1_data),
    .o_rd1_data (w_rs2_data)
  );

  bru_pipe u_pipe (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_issue_valid       (i_issue_valid),
    .i_issue_inst        (i_issue_inst),
    .i_issue_pc          (i_issue_pc),
    .i_issue_cmt_id      (i_issue_cmt_id),
    .i_issue_rs1         (i_issue_rs1),
    .i_issue_rs2         (i_issue_rs2),
    .i_issue_rd          (i_issue_rd),
    .i_issue_pred_taken  (i_issue_pred_taken),
    .i_issue_pred_target (i_issue_pred_target),
    .o_rs1_rnid          (w_rs1_rnid),
    .o_rs2_rnid          (w_rs2_rnid),
    .i_rs1_data          (w_rs1_data),
    .i_rs2_data          (w_rs2_data),
    .o_upd_valid         (o_upd_valid),
    .o_upd_cmt_id        (o_upd_cmt_id),
    .o_upd_pc            (o_upd_pc),
    .o_upd_taken         (o_upd_taken),
    .o_upd_target        (o_upd_target),
    .o_upd_mispredict    (o_upd_mispredict),
    .o_wr_valid          (o_wr_valid),
    .o_wr_rnid           (o_wr_rnid),
    .o_wr_data           (o_wr_data)
  );

endmodule

// File: source/bru_pipe.sv
// branch execution pipeline
`timescale 1ns/10ps

module bru_pipe (
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_issue_valid,
  input  bru_pkg::inst_t     i_issue_inst,
  input  bru_pkg::vaddr_t    i_issue_pc,
  input  bru_pkg::cmt_id_t   i_issue_cmt_id,
  input  bru_pkg::rnid_t     i_issue_rs1,
  input  bru_pkg::rnid_t     i_issue_rs2,
  input  bru_pkg::rnid_t     i_issue_rd,
  input  logic               i_issue_pred_taken,
  input  bru_pkg::vaddr_t    i_issue_pred_target,

  output bru_pkg::rnid_t     o_rs1_rnid,
  output bru_pkg::rnid_t     o_rs2_rnid,
  input  bru_pkg::xlen_t     i_rs1_data,
  input  bru_pkg::xlen_t     i_rs2_data,

  output logic               o_upd_valid,
  output bru_pkg::cmt_id_t   o_upd_cmt_id,
  output bru_pkg::vaddr_t    o_upd_pc,
  output logic               o_upd_taken,
  output bru_pkg::vaddr_t    o_upd_target,
  output logic               o_upd_mispredict,

  output logic               o_wr_valid,
  output bru_pkg::rnid_t     o_wr_rnid,
  output bru_pkg::xlen_t     o_wr_data
);

  import bru_pkg::*;

  // ------------------------------
  // ex0
  // ------------------------------
  logic    r_ex0_valid;
  inst_t   r_ex0_inst;
  vaddr_t  r_ex0_pc;
  cmt_id_t r_ex0_cmt_id;
  rnid_t   r_ex0_rd;
  logic    r_ex0_pred_taken;
  vaddr_t  r_ex0_pred_target;
  op_t     w_ex0_op;
  imm_t    w_ex0_imm;
  logic    w_ex0_is_cond;
  logic    w_ex0_wr_rd;
  logic    w_ex0_kill;

  // ex1
  logic    r_ex1_valid;
  inst_t   r_ex1_inst;
  vaddr_t  r_ex1_pc;
  cmt_id_t r_ex1_cmt_id;
  rnid_t   r_ex1_rd;
  logic    r_ex1_pred_taken;
  vaddr_t  r_ex1_pred_target;
  op_t     r_ex1_op;
  imm_t    r_ex1_imm;
  logic    r_ex1_is_cond;
  logic    r_ex1_wr_rd;
  xlen_t   r_ex1_rs1_data;
  xlen_t   r_ex1_rs2_data;
  vaddr_t  w_ex1_off_sb;
  vaddr_t  w_ex1_off_uj;
  vaddr_t  w_ex1_jalr_sum;
  vaddr_t  w_ex1_target;
  logic    w_ex1_result;
  logic    w_ex1_kill;

  // ex2
  logic    r_ex2_valid;
  vaddr_t  r_ex2_pc;
  cmt_id_t r_ex2_cmt_id;
  rnid_t   r_ex2_rd;
  logic    r_ex2_pred_taken;
  vaddr_t  r_ex2_pred_target;
  logic    r_ex2_is_cond;
  logic    r_ex2_wr_rd;
  logic    r_ex2_result;
  vaddr_t  r_ex2_target;
  vaddr_t  w_ex2_pc_next;
  logic    w_ex2_taken;
  logic    w_ex2_mispredict;
  logic    w_ex2_flush;

  // read addresses go out with the issue, data lands while the branch sits in ex0
  assign o_rs1_rnid = i_issue_rs1;
  assign o_rs2_rnid = i_issue_rs2;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex0_valid <= i_issue_valid;
      r_ex1_valid <= r_ex0_valid & ~w_ex0_kill;
      r_ex2_valid <= r_ex1_valid & ~w_ex1_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_inst        <= i_issue_inst;
    r_ex0_pc          <= i_issue_pc;
    r_ex0_cmt_id      <= i_issue_cmt_id;
    r_ex0_rd          <= i_issue_rd;
    r_ex0_pred_taken  <= i_issue_pred_taken;
    r_ex0_pred_target <= i_issue_pred_target;
  end

  bru_decoder u_decoder (
    .i_inst    (r_ex0_inst),
    .o_op      (w_ex0_op),
    .o_imm     (w_ex0_imm),
    .o_is_cond (w_ex0_is_cond),
    .o_wr_rd   (w_ex0_wr_rd)
  );

  // younger than a mispredicting branch at the update port
  assign w_ex2_flush = r_ex2_valid & w_ex2_mispredict;
  assign w_ex0_kill  = w_ex2_flush & is_younger(r_ex0_cmt_id, r_ex2_cmt_id);
  assign w_ex1_kill  = w_ex2_flush & is_younger(r_ex1_cmt_id, r_ex2_cmt_id);

  always_ff @(posedge i_clk) begin
    r_ex1_inst        <= r_ex0_inst;
    r_ex1_pc          <= r_ex0_pc;
    r_ex1_cmt_id      <= r_ex0_cmt_id;
    r_ex1_rd          <= r_ex0_rd;
    r_ex1_pred_taken  <= r_ex0_pred_taken;
    r_ex1_pred_target <= r_ex0_pred_target;
    r_ex1_op          <= w_ex0_op;
    r_ex1_imm         <= w_ex0_imm;
    r_ex1_is_cond     <= w_ex0_is_cond;
    r_ex1_wr_rd       <= w_ex0_wr_rd;
    r_ex1_rs1_data    <= i_rs1_data;
    r_ex1_rs2_data    <= i_rs2_data;
  end

  // ------------------------------
  // ex1 target and compare
  // ------------------------------
  assign w_ex1_off_sb = {{19{r_ex1_inst[31]}}, r_ex1_inst[31], r_ex1_inst[7],
                         r_ex1_inst[30:25], r_ex1_inst[11:8], 1'b0};
  assign w_ex1_off_uj = {{11{r_ex1_inst[31]}}, r_ex1_inst[31], r_ex1_inst[19:12],
                         r_ex1_inst[20], r_ex1_inst[30:21], 1'b0};
  assign w_ex1_jalr_sum = r_ex1_rs1_data + {{20{r_ex1_inst[31]}}, r_ex1_inst[31:20]};

  always_comb begin
    case (r_ex1_imm)
      IMM_UJ:  w_ex1_target = r_ex1_pc + w_ex1_off_uj;
      IMM_I:   w_ex1_target = {w_ex1_jalr_sum[XLEN-1:1], 1'b0}; // jalr drops bit 0
      default: w_ex1_target = r_ex1_pc + w_ex1_off_sb;
    endcase
  end

  always_comb begin
    case (r_ex1_op)
      OP_EQ:   w_ex1_result = r_ex1_rs1_data == r_ex1_rs2_data;
      OP_NE:   w_ex1_result = r_ex1_rs1_data != r_ex1_rs2_data;
      OP_LT:   w_ex1_result = $signed(r_ex1_rs1_data) < $signed(r_ex1_rs2_data);
      OP_GE:   w_ex1_result = $signed(r_ex1_rs1_data) >= $signed(r_ex1_rs2_data);
      OP_LTU:  w_ex1_result = r_ex1_rs1_data < r_ex1_rs2_data;
      OP_GEU:  w_ex1_result = r_ex1_rs1_data >= r_ex1_rs2_data;
      default: w_ex1_result = 1'b0; // jumps take via is_cond
    endcase
  end

  always_ff @(posedge i_clk) begin
    r_ex2_pc          <= r_ex1_pc;
    r_ex2_cmt_id      <= r_ex1_cmt_id;
    r_ex2_rd          <= r_ex1_rd;
    r_ex2_pred_taken  <= r_ex1_pred_taken;
    r_ex2_pred_target <= r_ex1_pred_target;
    r_ex2_is_cond     <= r_ex1_is_cond;
    r_ex2_wr_rd       <= r_ex1_wr_rd;
    r_ex2_result      <= w_ex1_result;
    r_ex2_target      <= w_ex1_target;
  end

  // ------------------------------
  // ex2 result, seen as ex3
  // ------------------------------
  assign w_ex2_pc_next    = r_ex2_pc + vaddr_t'(4);
  assign w_ex2_taken      = ~r_ex2_is_cond | r_ex2_result;
  assign w_ex2_mispredict = (w_ex2_taken != r_ex2_pred_taken) |
                            (w_ex2_taken & r_ex2_pred_taken &
                             (r_ex2_target != r_ex2_pred_target));

  assign o_upd_valid      = r_ex2_valid;
  assign o_upd_cmt_id     = r_ex2_cmt_id;
  assign o_upd_pc         = r_ex2_pc;
  assign o_upd_taken      = w_ex2_taken;
  assign o_upd_target     = w_ex2_taken ? r_ex2_target : w_ex2_pc_next;
  assign o_upd_mispredict = w_ex2_mispredict;

  assign o_wr_valid = r_ex2_valid & r_ex2_wr_rd;
  assign o_wr_rnid  = r_ex2_rd;
  assign o_wr_data  = xlen_t'(w_ex2_pc_next); // link value

endmodule

// File: source/bru_regfile.sv
// physical register file
`timescale 1ns/10ps

module bru_regfile #(
  parameter int PHY_REG_NUM = 64
) (
  input  logic           i_clk,
  input  logic           i_reset_n,

  input  logic           i_wr_valid,
  input  bru_pkg::rnid_t i_wr_rnid,
  input  bru_pkg::xlen_t i_wr_data,

  input  bru_pkg::rnid_t i_rd0_rnid,
  input  bru_pkg::rnid_t i_rd1_rnid,
  output bru_pkg::xlen_t o_rd0_data,
  output bru_pkg::xlen_t o_rd1_data
);

  import bru_pkg::*;

  xlen_t r_regs [PHY_REG_NUM];
  xlen_t r_rd0_data;
  xlen_t r_rd1_data;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < PHY_REG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_wr_valid) begin
      r_regs[i_wr_rnid] <= i_wr_data;
    end
  end

  // registered reads, a write on the same edge is not seen
  always_ff @(posedge i_clk) begin
    r_rd0_data <= r_regs[i_rd0_rnid];
    r_rd1_data <= r_regs[i_rd1_rnid];
  end

  assign o_rd0_data = r_rd0_data;
  assign o_rd1_data = r_rd1_data;

endmodule

// File: source/bru_decoder.sv
// branch instruction decoder
`timescale 1ns/10ps

module bru_decoder (
  input  bru_pkg::inst_t i_inst,
  output bru_pkg::op_t   o_op,
  output bru_pkg::imm_t  o_imm,
  output logic           o_is_cond,
  output logic           o_wr_rd
);

  import bru_pkg::*;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic       w_rd_nz;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_rd_nz  = i_inst[11:7] != 5'd0;

  always_comb begin
    // unknown encodings fall through as a jump with no link write
    o_op      = OP_JUMP;
    o_imm     = IMM_I;
    o_is_cond = 1'b0;
    o_wr_rd   = 1'b0;
    case (w_opcode)
      OPC_BRANCH: begin
        o_imm     = IMM_SB;
        o_is_cond = 1'b1;
        case (w_funct3)
          3'b000:  o_op = OP_EQ;
          3'b001:  o_op = OP_NE;
          3'b100:  o_op = OP_LT;
          3'b101:  o_op = OP_GE;
          3'b110:  o_op = OP_LTU;
          3'b111:  o_op = OP_GEU;
          default: o_is_cond = 1'b0; // reserved funct3
        endcase
      end
      OPC_JAL: begin
        o_imm   = IMM_UJ;
        o_wr_rd = w_rd_nz;
      end
      OPC_JALR: begin
        o_wr_rd = w_rd_nz & (w_funct3 == 3'b000);
      end
      default: ;
    endcase
  end

endmodule

// File: source/bru_pkg.sv
// branch unit shared definitions

package bru_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int XLEN     = 32;
  localparam int RNID_W   = 6;
  localparam int CMT_ID_W = 6;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [XLEN-1:0]     vaddr_t;  // no translation here, same as data
  typedef logic [31:0]         inst_t;
  typedef logic [RNID_W-1:0]   rnid_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t; // program order, wraps

  // ------------------------------
  // decode results
  // ------------------------------
  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP   // unconditional
  } op_t;

  typedef enum logic [1:0] {
    IMM_SB,
    IMM_UJ,
    IMM_I
  } imm_t;

  // a younger than b, modulo the commit id space
  function automatic logic is_younger(input cmt_id_t a, input cmt_id_t b);
    cmt_id_t diff;
    diff = a - b;
    return !diff[CMT_ID_W-1] && (a != b);
  endfunction

endpackage
